// ==== src.f ====
+incdir+source
source/rob_pkg.sv
source/rob_line.sv
source/rob_dispatch.sv
source/rob_store.sv
source/rob_commit.sv
source/rob_top.sv
tb/rob_props.sv
tb/rob_tb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := rob_tb
FILELIST := src.f
BUILD    := obj_dir
LOG      := sim.log
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0

SOURCES  := $(shell grep -E '\.s?v$$' $(FILELIST)) $(wildcard source/*.svh)
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb/rob_tb.sv ====
`include "rob_defines.svh"

`default_nettype none

module rob_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [1:0] {OP_IDLE, OP_DISPATCH, OP_WB} op_t;

  // one stimulus row, wb rows pick the idx-th oldest entry still waiting.
  typedef struct packed {
    logic [2:0]             test;
    op_t                    op;
    logic                   we;
    logic [`REG_ADDR_W-1:0] addr;
    logic [`EXC_W-1:0]      exc;
    logic [`ROB_TAG_W-1:0]  idx;
  } row_t;

  typedef struct packed {
    rob_pkg::commit_t rec;
    logic             done;
  } ref_t;

  logic                   clk;
  logic                   rst;
  logic                   dispatch_valid;
  rob_pkg::dec_inst_t     dispatch_inst;
  logic                   rob_full;
  logic [`ROB_TAG_W-1:0]  dispatch_tag;
  logic                   wb_valid;
  rob_pkg::wb_t           wb;
  logic                   commit_valid;
  rob_pkg::commit_t       commit;
  logic                   flush;

  row_t                   rows [$];
  ref_t                   model [$];   // accepted instructions, oldest first.
  string                  test_name [7];
  logic [`ROB_TAG_W-1:0]  tail;
  logic [15:0]            lfsr;
  int                     checks = 0;
  int                     errors = 0;
  int                     test_start_errors = 0;
  int                     cycles = 0;
  int                     limit = 0;

  rob_top UUT (
    .clk            (clk),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch_inst  (dispatch_inst),
    .rob_full       (rob_full),
    .dispatch_tag   (dispatch_tag),
    .wb_valid       (wb_valid),
    .wb             (wb),
    .commit_valid   (commit_valid),
    .commit         (commit),
    .flush          (flush)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // galois form of x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] word;
    for (int i = 0; i < 32; i++) begin
      word[i] = lfsr[0];
      lfsr    = lfsr_step(lfsr);
    end
    return word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic add_row(input logic [2:0] test, input op_t op, input logic we,
                         input logic [`REG_ADDR_W-1:0] addr, input logic [`EXC_W-1:0] exc,
                         input logic [`ROB_TAG_W-1:0] idx);
    rows.push_back('{test, op, we, addr, exc, idx});
  endtask

  task automatic build_table();
    for (int i = 0; i < 3; i++) add_row(3'd1, OP_IDLE, 1'b0, 5'd0, 4'd0, 3'd0);
    for (int i = 0; i < 4; i++) add_row(3'd2, OP_DISPATCH, 1'b1, 5'(i + 1), 4'd0, 3'd0);
    for (int i = 3; i >= 0; i--) add_row(3'd2, OP_WB, 1'b0, 5'd0, 4'd0, 3'(i));
    for (int i = 0; i < 6; i++) add_row(3'd2, OP_IDLE, 1'b0, 5'd0, 4'd0, 3'd0);
    for (int i = 0; i < 9; i++) add_row(3'd3, OP_DISPATCH, 1'b1, 5'(i + 8), 4'd0, 3'd0);
    add_row(3'd3, OP_WB, 1'b0, 5'd0, 4'd0, 3'd0);
    for (int i = 0; i < 3; i++) add_row(3'd3, OP_IDLE, 1'b0, 5'd0, 4'd0, 3'd0);
    for (int i = 0; i < 7; i++) add_row(3'd3, OP_WB, 1'b0, 5'd0, 4'd0, 3'd0);
    for (int i = 0; i < 6; i++) add_row(3'd3, OP_IDLE, 1'b0, 5'd0, 4'd0, 3'd0);
    add_row(3'd4, OP_DISPATCH, 1'b0, 5'd9, 4'd0, 3'd0);
    add_row(3'd4, OP_WB, 1'b0, 5'd0, 4'd0, 3'd0);
    for (int i = 0; i < 4; i++) add_row(3'd4, OP_IDLE, 1'b0, 5'd0, 4'd0, 3'd0);
    for (int i = 0; i < 3; i++) add_row(3'd5, OP_DISPATCH, 1'b1, 5'(i + 20), 4'd0, 3'd0);
    add_row(3'd5, OP_WB, 1'b0, 5'd0, 4'd0, 3'd1);
    add_row(3'd5, OP_WB, 1'b0, 5'd0, 4'h5, 3'd0);   // faulting head.
    for (int i = 0; i < 5; i++) add_row(3'd5, OP_IDLE, 1'b0, 5'd0, 4'd0, 3'd0);
    add_row(3'd5, OP_DISPATCH, 1'b1, 5'd23, 4'd0, 3'd0);
    add_row(3'd5, OP_WB, 1'b0, 5'd0, 4'd0, 3'd0);
    for (int i = 0; i < 4; i++) add_row(3'd5, OP_IDLE, 1'b0, 5'd0, 4'd0, 3'd0);
    add_row(3'd6, OP_DISPATCH, 1'b1, 5'd24, 4'h3, 3'd0);
    add_row(3'd6, OP_DISPATCH, 1'b1, 5'd25, 4'd0, 3'd0);
    for (int i = 0; i < 5; i++) add_row(3'd6, OP_IDLE, 1'b0, 5'd0, 4'd0, 3'd0);
    add_row(3'd6, OP_DISPATCH, 1'b1, 5'd26, 4'd0, 3'd0);
    add_row(3'd6, OP_WB, 1'b0, 5'd0, 4'd0, 3'd0);
    for (int i = 0; i < 4; i++) add_row(3'd6, OP_IDLE, 1'b0, 5'd0, 4'd0, 3'd0);
  endtask

  task automatic drive_row(input row_t row, input int r);
    int pend;
    int pick;
    pend = 0;
    pick = -1;
    dispatch_valid <= 1'b0;
    wb_valid       <= 1'b0;
    if (row.op == OP_DISPATCH) begin
      dispatch_valid               <= 1'b1;
      dispatch_inst.reg_write_en   <= row.we;
      dispatch_inst.reg_write_addr <= row.addr;
      dispatch_inst.pc             <= 32'h0000_4000 + 32'(r * 4);
      dispatch_inst.exc            <= row.exc;
    end else if (row.op == OP_WB) begin
      foreach (model[i]) begin
        if (!model[i].done && pick < 0) begin
          if (pend == int'(row.idx)) pick = i;
          pend++;
        end
      end
      if (pick >= 0) begin
        model[pick].done     = 1'b1;
        model[pick].rec.data = rand_word();
        model[pick].rec.exc  = row.exc;
        wb_valid <= 1'b1;
        wb.tag   <= model[pick].rec.tag;
        wb.data  <= model[pick].rec.data;
        wb.exc   <= row.exc;
      end
    end
  endtask

  task automatic observe(input row_t row);
    ref_t entry;
    logic flush_exp;
    logic full_exp;
    flush_exp = 1'b0;
    if (commit_valid && model.size() == 0) begin
      errors++;
      $display("a commit came out while no instruction was outstanding at %0t", $time);
    end else if (commit_valid) begin
      entry = model.pop_front();
      check_value("commit.tag", 32'(commit.tag), 32'(entry.rec.tag));
      check_value("commit.reg_write_en", 32'(commit.reg_write_en), 32'(entry.rec.reg_write_en));
      check_value("commit.reg_write_addr", 32'(commit.reg_write_addr),
                  32'(entry.rec.reg_write_addr));
      check_value("commit.data", commit.data, entry.rec.data);
      check_value("commit.pc", commit.pc, entry.rec.pc);
      check_value("commit.exc", 32'(commit.exc), 32'(entry.rec.exc));
      flush_exp = |entry.rec.exc;
      if (flush_exp) begin
        model.delete();   // younger entries are squashed.
        tail = '0;
      end
    end
    check_value("flush", 32'(flush), 32'(flush_exp));
    full_exp = (model.size() == `ROB_DEPTH);
    check_value("rob_full", 32'(rob_full), 32'(full_exp));
    if (row.op == OP_DISPATCH && !full_exp && !flush_exp) begin
      check_value("dispatch_tag", 32'(dispatch_tag), 32'(tail));
      entry                    = '0;
      entry.rec.tag            = tail;
      entry.rec.reg_write_en   = dispatch_inst.reg_write_en;
      entry.rec.reg_write_addr = dispatch_inst.reg_write_addr;
      entry.rec.pc             = dispatch_inst.pc;
      entry.rec.exc            = dispatch_inst.exc;
      entry.done               = |dispatch_inst.exc;
      model.push_back(entry);
      tail = tail + `ROB_TAG_W'(1);
    end
  endtask

  initial begin
    rst            = 1'b0;
    dispatch_valid = 1'b0;
    dispatch_inst  = '0;
    wb_valid       = 1'b0;
    wb             = '0;
    tail           = '0;
    lfsr           = 16'd13158;
    test_name[1] = "reset state";
    test_name[2] = "reverse writeback order";
    test_name[3] = "full buffer";
    test_name[4] = "register write disabled";
    test_name[5] = "writeback exception";
    test_name[6] = "decode exception";
    build_table();
    limit = rows.size() * `ROB_DEPTH + 50;
    repeat (4) @(posedge clk);
    rst <= 1'b1;
    for (int r = 0; r < rows.size(); r++) begin
      @(posedge clk);
      drive_row(rows[r], r);
      @(negedge clk);
      observe(rows[r]);
      if (r == rows.size() - 1 || rows[r + 1].test != rows[r].test) begin
        $display("test %0d (%s): %0d errors", rows[r].test, test_name[rows[r].test],
                 errors - test_start_errors);
        test_start_errors = errors;
      end
    end
    if (model.size() != 0) begin
      errors++;
      $display("%0d dispatched instructions never committed", model.size());
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/rob_props.sv ====
`include "rob_defines.svh"

`default_nettype none

module rob_props #(
  parameter int CNT_W = $clog2(`ROB_DEPTH + 1)
) (
  input wire             clk,
  input wire             rst,
  input wire [CNT_W-1:0] count,
  input wire             rob_full,
  input wire             commit_valid,
  input wire             flush,
  input wire             head_valid,
  input wire             head_done
);
  timeunit 1ns;
  timeprecision 1ps;

  count_bounded: assert property (@(posedge clk) disable iff (!rst)
    count <= CNT_W'(`ROB_DEPTH))
    else $error("occupancy count above buffer depth");

  commit_needs_done: assert property (@(posedge clk) disable iff (!rst)
    commit_valid |-> $past(head_valid && head_done))
    else $error("commit taken from a head that is not done");

  flush_with_commit: assert property (@(posedge clk) disable iff (!rst)
    flush |-> commit_valid)
    else $error("flush raised without a commit");

  reset_quiet: assert property (@(posedge clk)
    !rst |=> !commit_valid && !rob_full && !flush)
    else $error("commit_valid, rob_full or flush high after reset");

endmodule

bind rob_top rob_props u_props (
  .clk          (clk),
  .rst          (rst),
  .count        (u_store.count),
  .rob_full     (rob_full),
  .commit_valid (commit_valid),
  .flush        (flush),
  .head_valid   (head_result.valid),
  .head_done    (head_result.done)
);

`default_nettype wire

// ==== source/rob_top.sv ====
`include "rob_defines.svh"

`default_nettype none

module rob_top (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    dispatch_valid,
  input  rob_pkg::dec_inst_t     dispatch_inst,
  output logic                   rob_full,
  output logic [`ROB_TAG_W-1:0]  dispatch_tag,
  input  wire                    wb_valid,
  input  rob_pkg::wb_t           wb,
  output logic                   commit_valid,
  output rob_pkg::commit_t       commit,
  output logic                   flush
);

  logic                  alloc;
  logic [`ROB_TAG_W-1:0] alloc_tag;
  rob_pkg::rob_entry_t   alloc_entry;
  rob_pkg::rob_result_t  alloc_result;
  logic                  retire;
  logic [`ROB_TAG_W-1:0] head_tag;
  rob_pkg::rob_entry_t   head_entry;
  rob_pkg::rob_result_t  head_result;

  rob_dispatch u_dispatch (
    .clk            (clk),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch_inst  (dispatch_inst),
    .rob_full       (rob_full),
    .flush          (flush),
    .alloc          (alloc),
    .alloc_tag      (alloc_tag),
    .alloc_entry    (alloc_entry),
    .alloc_result   (alloc_result),
    .dispatch_tag   (dispatch_tag)
  );

  rob_store u_store (
    .clk          (clk),
    .rst          (rst),
    .alloc        (alloc),
    .alloc_tag    (alloc_tag),
    .alloc_entry  (alloc_entry),
    .alloc_result (alloc_result),
    .wb_valid     (wb_valid),
    .wb           (wb),
    .retire       (retire),
    .flush        (flush),
    .head_tag     (head_tag),
    .rob_full     (rob_full),
    .head_entry   (head_entry),
    .head_result  (head_result)
  );

  rob_commit u_commit (
    .clk          (clk),
    .rst          (rst),
    .head_entry   (head_entry),
    .head_result  (head_result),
    .head_tag     (head_tag),
    .retire       (retire),
    .commit_valid (commit_valid),
    .commit       (commit),
    .flush        (flush)
  );

endmodule

`default_nettype wire

// ==== source/rob_commit.sv ====
`include "rob_defines.svh"

`default_nettype none

module rob_commit (
  input  wire                    clk,
  input  wire                    rst,
  input  rob_pkg::rob_entry_t    head_entry,
  input  rob_pkg::rob_result_t   head_result,
  output logic [`ROB_TAG_W-1:0]  head_tag,
  output logic                   retire,
  output logic                   commit_valid,
  output rob_pkg::commit_t       commit,
  output logic                   flush
);

  localparam logic [`ROB_TAG_W-1:0] LAST_TAG = `ROB_TAG_W'(`ROB_DEPTH - 1);

  logic [`ROB_TAG_W-1:0] head_q;

  // nothing retires while the buffer is being flushed.
  assign retire   = head_result.valid && head_result.done && !flush;
  assign head_tag = head_q;

  always_ff @(posedge clk) begin
    if (!rst) begin
      head_q       <= '0;
      commit_valid <= 1'b0;
      flush        <= 1'b0;
    end else begin
      commit_valid <= retire;
      flush        <= retire && (|head_result.exc);
      if (flush) begin
        head_q <= '0;
      end else if (retire) begin
        head_q <= (head_q == LAST_TAG) ? '0 : head_q + 1'b1;
      end
    end
  end

  // retired record, held until the next commit.
  always_ff @(posedge clk) begin
    if (retire) begin
      commit.tag            <= head_q;
      commit.reg_write_en   <= head_entry.reg_write_en;
      commit.reg_write_addr <= head_entry.reg_write_addr;
      commit.data           <= head_result.data;
      commit.pc             <= head_entry.pc;
      commit.exc            <= head_result.exc;
    end
  end

endmodule

`default_nettype wire

// ==== source/rob_store.sv ====
`include "rob_defines.svh"

`default_nettype none

module rob_store (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   alloc,
  input  wire [`ROB_TAG_W-1:0]  alloc_tag,
  input  rob_pkg::rob_entry_t   alloc_entry,
  input  rob_pkg::rob_result_t  alloc_result,
  input  wire                   wb_valid,
  input  rob_pkg::wb_t          wb,
  input  wire                   retire,
  input  wire                   flush,
  input  wire [`ROB_TAG_W-1:0]  head_tag,
  output logic                  rob_full,
  output rob_pkg::rob_entry_t   head_entry,
  output rob_pkg::rob_result_t  head_result
);

  localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

  rob_pkg::rob_entry_t  entry_q  [`ROB_DEPTH];
  rob_pkg::rob_result_t result_q [`ROB_DEPTH];
  rob_pkg::rob_result_t result_d [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] entry_we;
  logic [`ROB_DEPTH-1:0] result_we;

  logic [CNT_W-1:0] count;

  for (genvar i = 0; i < `ROB_DEPTH; i++) begin : g_line
    rob_line #(
      .line_t(rob_pkg::rob_entry_t)
    ) u_entry (
      .clk      (clk),
      .rst      (rst),
      .write_en (entry_we[i]),
      .data_in  (alloc_entry),
      .data_out (entry_q[i])
    );

    rob_line #(
      .line_t(rob_pkg::rob_result_t)
    ) u_result (
      .clk      (clk),
      .rst      (rst),
      .write_en (result_we[i]),
      .data_in  (result_d[i]),
      .data_out (result_q[i])
    );
  end

  // payload is written once, at dispatch.
  always_comb begin
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      entry_we[i] = alloc && !flush && (alloc_tag == `ROB_TAG_W'(i));
    end
  end

  // result line update, flush first, then alloc, retire, writeback.
  always_comb begin
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      result_we[i] = 1'b0;
      result_d[i]  = result_q[i];
      if (flush) begin
        result_we[i] = 1'b1;
        result_d[i]  = '0;
      end else if (alloc && alloc_tag == `ROB_TAG_W'(i)) begin
        result_we[i] = 1'b1;
        result_d[i]  = alloc_result;
      end else if (retire && head_tag == `ROB_TAG_W'(i)) begin
        result_we[i] = 1'b1;
        result_d[i]  = '0;
      end else if (wb_valid && wb.tag == `ROB_TAG_W'(i) && result_q[i].valid) begin
        result_we[i]      = 1'b1;
        result_d[i].done  = 1'b1;       // valid flag is kept.
        result_d[i].data  = wb.data;
        result_d[i].exc   = wb.exc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      count <= '0;
    end else if (flush) begin
      count <= '0;
    end else begin
      count <= count + CNT_W'(alloc) - CNT_W'(retire);
    end
  end

  assign rob_full = (count == CNT_W'(`ROB_DEPTH));

  assign head_entry  = entry_q[head_tag];
  assign head_result = result_q[head_tag];

endmodule

`default_nettype wire

// ==== source/rob_dispatch.sv ====
`include "rob_defines.svh"

`default_nettype none

module rob_dispatch (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    dispatch_valid,
  input  rob_pkg::dec_inst_t     dispatch_inst,
  input  wire                    rob_full,
  input  wire                    flush,
  output logic                   alloc,
  output logic [`ROB_TAG_W-1:0]  alloc_tag,
  output rob_pkg::rob_entry_t    alloc_entry,
  output rob_pkg::rob_result_t   alloc_result,
  output logic [`ROB_TAG_W-1:0]  dispatch_tag
);

  localparam logic [`ROB_TAG_W-1:0] LAST_TAG = `ROB_TAG_W'(`ROB_DEPTH - 1);

  logic [`ROB_TAG_W-1:0] tail_q;

  // a dispatch on the flush edge is lost.
  assign alloc = dispatch_valid && !rob_full && !flush;

  assign alloc_tag    = tail_q;
  assign dispatch_tag = tail_q;

  always_comb begin
    alloc_entry.reg_write_en   = dispatch_inst.reg_write_en;
    alloc_entry.reg_write_addr = dispatch_inst.reg_write_addr;
    alloc_entry.pc             = dispatch_inst.pc;
  end

  always_comb begin
    alloc_result.valid = 1'b1;
    alloc_result.done  = |dispatch_inst.exc;  // faulting decode needs no execute.
    alloc_result.data  = '0;
    alloc_result.exc   = dispatch_inst.exc;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      tail_q <= '0;
    end else if (flush) begin
      tail_q <= '0;
    end else if (alloc) begin
      tail_q <= (tail_q == LAST_TAG) ? '0 : tail_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/rob_line.sv ====
`default_nettype none

module rob_line #(
  parameter type line_t = logic
) (
  input  wire   clk,
  input  wire   rst,
  input  wire   write_en,
  input  line_t data_in,
  output line_t data_out
);

  line_t line_q;

  always_ff @(posedge clk) begin
    if (!rst) begin
      line_q <= '0;
    end else if (write_en) begin
      line_q <= data_in;
    end
  end

  assign data_out = line_q;

endmodule

`default_nettype wire

// ==== source/rob_pkg.sv ====
`include "rob_defines.svh"

`default_nettype none

package rob_pkg;

  // instruction as it leaves decode.
  typedef struct packed {
    logic                   reg_write_en;
    logic [`REG_ADDR_W-1:0] reg_write_addr;
    logic [31:0]            pc;
    logic [`EXC_W-1:0]      exc;          // decode-time exception.
  } dec_inst_t;

  typedef struct packed {
    logic                   reg_write_en;
    logic [`REG_ADDR_W-1:0] reg_write_addr;
    logic [31:0]            pc;
  } rob_entry_t;

  // written at dispatch and again at writeback.
  typedef struct packed {
    logic                   valid;
    logic                   done;
    logic [`DATA_W-1:0]     data;
    logic [`EXC_W-1:0]      exc;
  } rob_result_t;

  typedef struct packed {
    logic [`ROB_TAG_W-1:0]  tag;
    logic [`DATA_W-1:0]     data;
    logic [`EXC_W-1:0]      exc;
  } wb_t;

  typedef struct packed {
    logic [`ROB_TAG_W-1:0]  tag;
    logic                   reg_write_en;
    logic [`REG_ADDR_W-1:0] reg_write_addr;
    logic [`DATA_W-1:0]     data;
    logic [31:0]            pc;
    logic [`EXC_W-1:0]      exc;
  } commit_t;

endpackage

`default_nettype wire

// ==== source/rob_defines.svh ====
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// buffer geometry.
`define ROB_DEPTH   8
`define ROB_TAG_W   3

// datapath widths.
`define REG_ADDR_W  5
`define DATA_W      32
`define EXC_W       4   // zero is no exception.

`endif
